// ==== Makefile ====
TOP := tb_mcu_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f sources.f --top-module $(TOP)

sim:
	verilator --binary --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// ==== sources.f ====
src/core_pkg.sv
src/isa_pkg.sv
src/cpu_sequencer.sv
src/cpu_decode.sv
src/cpu_alu.sv
src/cpu_writeback.sv
src/mcu_core.sv
verif/tb_mcu_core.sv

// ==== src/core_pkg.sv ====
package core_pkg;

    ////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////

    localparam int DATA_W    = 8;
    localparam int CODE_W    = 16;
    localparam int RAM_AW    = 8;
    localparam int REG_IDX_W = 3;

    // one byte on the data path, ROM or RAM
    typedef logic [DATA_W-1:0] data_t;

    // full code space, default width of the PC
    typedef logic [CODE_W-1:0] code_addr_t;

    // internal data RAM address
    typedef logic [RAM_AW-1:0] ram_addr_t;

    // working register number, R0..R7
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage

// ==== src/cpu_alu.sv ====
`timescale 1ns/100ps

module cpu_alu
    import core_pkg::*;
    import isa_pkg::*;
(
    input  alu_op_t alu_op,
    input  logic    src_imm,
    input  data_t   acc,
    input  logic    cy,
    input  data_t   imm_byte,
    input  data_t   reg_byte,
    output data_t   alu_result,
    output logic    alu_carry
);

    data_t      opnd_b;
    logic [8:0] sum;

    assign opnd_b = src_imm ? imm_byte : reg_byte;

    // bit 8 of sum is the carry, or the borrow for SUBB
    always_comb begin
        case (alu_op)
            ALU_ADD:    sum = {1'b0, acc} + {1'b0, opnd_b};
            ALU_ADDC:   sum = {1'b0, acc} + {1'b0, opnd_b} + {8'd0, cy};
            ALU_SUBB:   sum = {1'b0, acc} - {1'b0, opnd_b} - {8'd0, cy};
            ALU_AND:    sum = {1'b0, acc & opnd_b};
            ALU_OR:     sum = {1'b0, acc | opnd_b};
            ALU_XOR:    sum = {1'b0, acc ^ opnd_b};
            ALU_PASS_B: sum = {1'b0, opnd_b};
            // carry out of INC is dropped in writeback
            ALU_INC:    sum = {1'b0, acc} + 9'd1;
            default:    sum = {1'b0, acc};
        endcase
    end

    assign alu_result = sum[7:0];
    assign alu_carry  = sum[8];

endmodule

// ==== src/cpu_decode.sv ====
`timescale 1ns/100ps

module cpu_decode
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     op_load,
    input  data_t    rom_byte,
    output logic     need_imm,
    output logic     need_reg,
    output reg_idx_t reg_idx,
    output alu_op_t  alu_op,
    output logic     src_imm,
    output logic     wr_acc,
    output logic     wr_ram,
    output logic     set_c,
    output logic     clr_c
);

    data_t op_q;
    data_t opcode;
    data_t rn_group;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            op_q <= OP_NOP;
        else if (op_load)
            op_q <= rom_byte;
    end

    // the arriving opcode is decoded in its own cycle so the next request
    // can go out with it
    assign opcode   = op_load ? rom_byte : op_q;
    assign rn_group = {opcode[7:3], 3'b000};
    assign reg_idx  = opcode[2:0];

    always_comb begin
        alu_op   = ALU_NONE;
        need_imm = 1'b0;
        need_reg = 1'b0;
        src_imm  = 1'b0;
        wr_acc   = 1'b0;
        wr_ram   = 1'b0;
        set_c    = 1'b0;
        clr_c    = 1'b0;
        case (opcode)
            OP_ADD_IMM:   alu_op = ALU_ADD;
            OP_ADDC_IMM:  alu_op = ALU_ADDC;
            OP_SUBB_IMM:  alu_op = ALU_SUBB;
            OP_ANL_IMM:   alu_op = ALU_AND;
            OP_ORL_IMM:   alu_op = ALU_OR;
            OP_XRL_IMM:   alu_op = ALU_XOR;
            OP_MOV_A_IMM: alu_op = ALU_PASS_B;
            OP_INC_A:     alu_op = ALU_INC;
            OP_CLR_C:     clr_c  = 1'b1;
            OP_SETB_C:    set_c  = 1'b1;
            default: begin
                case (rn_group)
                    OP_ADD_RN:   alu_op = ALU_ADD;
                    OP_ADDC_RN:  alu_op = ALU_ADDC;
                    OP_SUBB_RN:  alu_op = ALU_SUBB;
                    OP_ANL_RN:   alu_op = ALU_AND;
                    OP_ORL_RN:   alu_op = ALU_OR;
                    OP_XRL_RN:   alu_op = ALU_XOR;
                    OP_MOV_A_RN: alu_op = ALU_PASS_B;
                    OP_MOV_RN_A: wr_ram = 1'b1;
                    default:     alu_op = ALU_NONE;
                endcase
                need_reg = (alu_op != ALU_NONE);
            end
        endcase
        // two-byte forms take operand B from the code stream
        if (opcode[3:0] == 4'h4 && opcode != OP_INC_A && alu_op != ALU_NONE) begin
            need_imm = 1'b1;
            src_imm  = 1'b1;
        end
        wr_acc = (alu_op != ALU_NONE);
    end

    // the opcode load is a single-cycle pulse
    a_load_pulse : assert property (@(posedge clk) disable iff (rst)
        op_load |=> !op_load);

endmodule

// ==== src/cpu_sequencer.sv ====
`timescale 1ns/100ps

module cpu_sequencer
    import core_pkg::*;
    import isa_pkg::*;
#(
    parameter int CODE_AW = $bits(code_addr_t)
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_en,
    input  logic               cpu_restart,
    input  data_t              rom_byte,
    input  logic               rom_vld,
    input  data_t              ram_rd_byte,
    input  logic               ram_rd_vld,
    input  logic               need_imm,
    input  logic               need_reg,
    input  reg_idx_t           reg_idx,
    output logic               rom_en,
    output logic [CODE_AW-1:0] rom_addr,
    output logic               ram_rd_en,
    output ram_addr_t          ram_rd_addr,
    output logic               op_load,
    output data_t              imm_byte,
    output data_t              reg_byte,
    output logic               exec_en
);

    seq_state_t         state;
    seq_state_t         state_nxt;
    logic [CODE_AW-1:0] pc;
    logic               req_out;
    logic               fetch_arm;
    logic               issue_ok;

    ////////////////////////////////////////////////////////////
    // request issue
    ////////////////////////////////////////////////////////////

    assign issue_ok = cpu_en && !cpu_restart;
    assign op_load  = (state == S_WAIT_OP) && rom_vld;

    // opcode response issues the operand request in the same cycle;
    // a wait state entered while stalled issues it once cpu_en returns
    assign rom_en = issue_ok && ((state == S_FETCH && fetch_arm) ||
                                 (state == S_WAIT_IMM && !req_out) ||
                                 (op_load && need_imm));

    assign ram_rd_en = issue_ok && ((state == S_WAIT_RAM && !req_out) ||
                                    (op_load && !need_imm && need_reg));

    assign exec_en     = issue_ok && (state == S_EXEC);
    assign rom_addr    = pc;
    // bank 0 only
    assign ram_rd_addr = ram_addr_t'(reg_idx);

    always_comb begin
        state_nxt = state;
        if (cpu_restart) begin
            state_nxt = S_FETCH;
        end else begin
            case (state)
                S_FETCH:    if (rom_en) state_nxt = S_WAIT_OP;
                S_WAIT_OP:  if (rom_vld) begin
                    if (need_imm)
                        state_nxt = S_WAIT_IMM;
                    else if (need_reg)
                        state_nxt = S_WAIT_RAM;
                    else
                        state_nxt = S_EXEC;
                end
                S_WAIT_IMM: if (rom_vld) state_nxt = S_EXEC;
                S_WAIT_RAM: if (ram_rd_vld) state_nxt = S_EXEC;
                S_EXEC:     if (cpu_en) state_nxt = S_FETCH;
                default:    state_nxt = S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_FETCH;
            fetch_arm <= 1'b0;
        end else begin
            state     <= state_nxt;
            fetch_arm <= 1'b1;
        end
    end

    // one request in flight at most
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            req_out <= 1'b0;
        else if (cpu_restart)
            req_out <= 1'b0;
        else if (rom_en || ram_rd_en)
            req_out <= 1'b1;
        else if (rom_vld || ram_rd_vld)
            req_out <= 1'b0;
    end

    // pc steps past each code byte as it is requested
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pc <= '0;
        else if (cpu_restart)
            pc <= '0;
        else if (rom_en)
            pc <= pc + 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // operand capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == S_WAIT_IMM && rom_vld)
            imm_byte <= rom_byte;
        if (state == S_WAIT_RAM && ram_rd_vld)
            reg_byte <= ram_rd_byte;
    end

    // responses only land where a matching request is waiting
    a_rom_vld_state : assert property (@(posedge clk) disable iff (rst)
        rom_vld |-> req_out && (state == S_WAIT_OP || state == S_WAIT_IMM));

    a_ram_vld_state : assert property (@(posedge clk) disable iff (rst)
        ram_rd_vld |-> req_out && (state == S_WAIT_RAM));

endmodule

// ==== src/cpu_writeback.sv ====
`timescale 1ns/100ps

module cpu_writeback
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      exec_en,
    input  alu_op_t   alu_op,
    input  logic      wr_acc,
    input  logic      wr_ram,
    input  logic      set_c,
    input  logic      clr_c,
    input  reg_idx_t  reg_idx,
    input  data_t     alu_result,
    input  logic      alu_carry,
    output data_t     acc,
    output logic      cy,
    output logic      ram_wr_en,
    output ram_addr_t ram_wr_addr,
    output data_t     ram_wr_byte
);

    logic carry_op;

    // only the arithmetic group touches the carry
    assign carry_op = alu_op inside {ALU_ADD, ALU_ADDC, ALU_SUBB};

    ////////////////////////////////////////////////////////////
    // accumulator and carry
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            acc <= '0;
        else if (exec_en && wr_acc)
            acc <= alu_result;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cy <= 1'b0;
        end else if (exec_en) begin
            if (clr_c)
                cy <= 1'b0;
            else if (set_c)
                cy <= 1'b1;
            else if (carry_op)
                cy <= alu_carry;
        end
    end

    ////////////////////////////////////////////////////////////
    // MOV Rn,A store, bank 0
    ////////////////////////////////////////////////////////////

    assign ram_wr_en   = exec_en && wr_ram;
    assign ram_wr_addr = ram_addr_t'(reg_idx);
    assign ram_wr_byte = acc;

    // at most one store per instruction
    a_wr_single : assert property (@(posedge clk) disable iff (rst)
        ram_wr_en |-> exec_en ##1 !ram_wr_en);

endmodule

// ==== src/isa_pkg.sv ====
package isa_pkg;

    import core_pkg::*;

    ////////////////////////////////////////////////////////////
    // single opcodes
    ////////////////////////////////////////////////////////////

    localparam data_t OP_NOP       = 8'h00;
    localparam data_t OP_INC_A     = 8'h04;
    localparam data_t OP_ADD_IMM   = 8'h24;
    localparam data_t OP_ADDC_IMM  = 8'h34;
    localparam data_t OP_ORL_IMM   = 8'h44;
    localparam data_t OP_ANL_IMM   = 8'h54;
    localparam data_t OP_XRL_IMM   = 8'h64;
    localparam data_t OP_MOV_A_IMM = 8'h74;
    localparam data_t OP_SUBB_IMM  = 8'h94;
    localparam data_t OP_CLR_C     = 8'hC3;
    localparam data_t OP_SETB_C    = 8'hD3;

    ////////////////////////////////////////////////////////////
    // Rn groups, low three bits pick the register
    ////////////////////////////////////////////////////////////

    localparam data_t OP_ADD_RN    = 8'h28;
    localparam data_t OP_ADDC_RN   = 8'h38;
    localparam data_t OP_ORL_RN    = 8'h48;
    localparam data_t OP_ANL_RN    = 8'h58;
    localparam data_t OP_XRL_RN    = 8'h68;
    localparam data_t OP_SUBB_RN   = 8'h98;
    localparam data_t OP_MOV_A_RN  = 8'hE8;
    localparam data_t OP_MOV_RN_A  = 8'hF8;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_ADDC,
        ALU_SUBB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B,
        ALU_INC,
        ALU_NONE
    } alu_op_t;

    typedef enum logic [2:0] {
        S_FETCH,
        S_WAIT_OP,
        S_WAIT_IMM,
        S_WAIT_RAM,
        S_EXEC
    } seq_state_t;

endpackage

// ==== src/mcu_core.sv ====
`timescale 1ns/100ps

module mcu_core
    import core_pkg::*;
    import isa_pkg::*;
#(
    parameter int CODE_AW = $bits(code_addr_t)
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_en,
    input  logic               cpu_restart,
    output logic               rom_en,
    output logic [CODE_AW-1:0] rom_addr,
    input  data_t              rom_byte,
    input  logic               rom_vld,
    output logic               ram_rd_en,
    output ram_addr_t          ram_rd_addr,
    input  data_t              ram_rd_byte,
    input  logic               ram_rd_vld,
    output logic               ram_wr_en,
    output ram_addr_t          ram_wr_addr,
    output data_t              ram_wr_byte
);

    // sequencer and decode handshake
    logic     op_load;
    logic     need_imm;
    logic     need_reg;
    reg_idx_t reg_idx;

    // operands and control into the datapath
    data_t    imm_byte;
    data_t    reg_byte;
    logic     exec_en;
    alu_op_t  alu_op;
    logic     src_imm;
    logic     wr_acc;
    logic     wr_ram;
    logic     set_c;
    logic     clr_c;

    // datapath loop
    data_t    alu_result;
    logic     alu_carry;
    data_t    acc;
    logic     cy;

    cpu_sequencer #(
        .CODE_AW (CODE_AW)
    ) u_seq (.*);

    cpu_decode u_dec (.*);

    cpu_alu u_alu (.*);

    cpu_writeback u_wb (.*);

endmodule

// ==== verif/tb_mcu_core.sv ====
`timescale 1ns/100ps

module tb_mcu_core
    import core_pkg::*;
    import isa_pkg::*;
();

    localparam int PROG_LEN  = 200;
    localparam int BODY_LEN  = 192;
    localparam int END_ADDR  = PROG_LEN - 2;
    localparam int STALL_MAX = 400;

    logic       clk;
    logic       rst;
    logic       cpu_en;
    logic       cpu_restart;
    logic       rom_en;
    code_addr_t rom_addr;
    data_t      rom_byte;
    logic       rom_vld;
    logic       ram_rd_en;
    ram_addr_t  ram_rd_addr;
    data_t      ram_rd_byte;
    logic       ram_rd_vld;
    logic       ram_wr_en;
    ram_addr_t  ram_wr_addr;
    data_t      ram_wr_byte;

    data_t       prog [PROG_LEN];
    data_t       ram_mem [8];
    logic [31:0] rng;
    int unsigned exp_rom [$];
    int unsigned exp_rd [$];
    // write entries hold the address above the byte
    int unsigned exp_wr [$];
    int          errors;
    int          restart_at;
    int          n_instr;

    mcu_core #(.CODE_AW(16)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    function automatic int unsigned pick(int unsigned n);
        return next_rand() % n;
    endfunction

    function automatic logic two_byte(data_t op);
        return op inside {OP_ADD_IMM, OP_ADDC_IMM, OP_SUBB_IMM, OP_ANL_IMM,
                          OP_ORL_IMM, OP_XRL_IMM, OP_MOV_A_IMM};
    endfunction

    ////////////////////////////////////////////////////////////
    // random program and reference model
    ////////////////////////////////////////////////////////////

    task automatic build_program();
        data_t imm_ops [7] = '{OP_ADD_IMM, OP_ADDC_IMM, OP_SUBB_IMM, OP_ANL_IMM,
                               OP_ORL_IMM, OP_XRL_IMM, OP_MOV_A_IMM};
        data_t rn_ops [10] = '{OP_ADD_RN, OP_ADDC_RN, OP_SUBB_RN, OP_ANL_RN, OP_ORL_RN,
                               OP_XRL_RN, OP_MOV_A_RN, OP_MOV_RN_A, OP_MOV_RN_A,
                               OP_MOV_RN_A};
        // last four are not in the kept set
        data_t one_ops [8] = '{OP_NOP, OP_INC_A, OP_CLR_C, OP_SETB_C,
                               8'h14, 8'h80, 8'hA4, 8'hE4};
        int          pos;
        int          i;
        int unsigned kind;
        pos = 0;
        while (pos < BODY_LEN) begin
            kind = pick(8);
            if (kind < 4)
                prog[pos] = rn_ops[pick(10)] | data_t'(pick(8));
            else if (kind < 6)
                prog[pos] = imm_ops[pick(7)];
            else
                prog[pos] = one_ops[pick(8)];
            pos++;
            if (two_byte(prog[pos-1])) begin
                prog[pos] = data_t'(next_rand());
                pos++;
            end
        end
        // tail of NOPs, every address from BODY_LEN+1 on is an opcode
        for (i = pos; i < PROG_LEN; i++)
            prog[i] = OP_NOP;
        for (i = 0; i < 8; i++)
            ram_mem[i] = data_t'(next_rand());
    endtask

    task automatic run_model();
        data_t acc;
        logic  cy;
        data_t regs [8];
        data_t op;
        data_t grp;
        data_t b;
        int    t;
        int    pc;
        int    writes;
        acc = 8'h00;
        cy = 1'b0;
        regs = ram_mem;
        pc = 0;
        writes = 0;
        n_instr = 0;
        while (pc < END_ADDR) begin
            exp_rom.push_back(pc);
            op = prog[pc];
            grp = op & 8'hF8;
            b = regs[op[2:0]];
            pc++;
            n_instr++;
            if (two_byte(op)) begin
                exp_rom.push_back(pc);
                b = prog[pc];
                pc++;
            end else if (grp inside {OP_ADD_RN, OP_ADDC_RN, OP_SUBB_RN, OP_ANL_RN,
                                     OP_ORL_RN, OP_XRL_RN, OP_MOV_A_RN}) begin
                exp_rd.push_back(op[2:0]);
            end
            t = int'(acc);
            if (op == OP_ADD_IMM || grp == OP_ADD_RN) begin
                t = int'(acc) + int'(b);
                cy = (t > 255);
            end else if (op == OP_ADDC_IMM || grp == OP_ADDC_RN) begin
                t = int'(acc) + int'(b) + int'(cy);
                cy = (t > 255);
            end else if (op == OP_SUBB_IMM || grp == OP_SUBB_RN) begin
                // borrow out lands in the carry
                t = int'(acc) - int'(b) - int'(cy);
                cy = (t < 0);
            end else if (op == OP_ANL_IMM || grp == OP_ANL_RN) begin
                t = int'(acc & b);
            end else if (op == OP_ORL_IMM || grp == OP_ORL_RN) begin
                t = int'(acc | b);
            end else if (op == OP_XRL_IMM || grp == OP_XRL_RN) begin
                t = int'(acc ^ b);
            end else if (op == OP_MOV_A_IMM || grp == OP_MOV_A_RN) begin
                t = int'(b);
            end else if (op == OP_INC_A) begin
                t = int'(acc) + 1;
            end else if (op == OP_CLR_C) begin
                cy = 1'b0;
            end else if (op == OP_SETB_C) begin
                cy = 1'b1;
            end else if (grp == OP_MOV_RN_A) begin
                regs[op[2:0]] = acc;
                exp_wr.push_back(int'(op[2:0]) * 256 + int'(acc));
                writes++;
                // restart after this store, acc and cy stay
                if (writes == restart_at)
                    pc = 0;
            end
            acc = data_t'(t);
        end
        exp_rom.push_back(END_ADDR);
    endtask

    ////////////////////////////////////////////////////////////
    // bus responders, stalls and checks
    ////////////////////////////////////////////////////////////

    task automatic run_bus(input int limit);
        int unsigned rom_pend;
        int unsigned rd_pend;
        int unsigned exp_v;
        int          rom_wait;
        int          rd_wait;
        int          stall_left;
        int          stall_used;
        int          cycles;
        int          writes;
        logic        restart_due;
        logic        done;
        rom_pend = 0;
        rd_pend = 0;
        rom_wait = 0;
        rd_wait = 0;
        stall_left = 0;
        stall_used = 0;
        cycles = 0;
        writes = 0;
        restart_due = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            rom_vld = 1'b0;
            ram_rd_vld = 1'b0;
            if (rom_wait > 0) begin
                rom_wait--;
                if (rom_wait == 0) begin
                    rom_vld = 1'b1;
                    rom_byte = (rom_pend < PROG_LEN) ? prog[rom_pend] : OP_NOP;
                end
            end
            if (rd_wait > 0) begin
                rd_wait--;
                if (rd_wait == 0) begin
                    ram_rd_vld = 1'b1;
                    ram_rd_byte = ram_mem[rd_pend % 8];
                end
            end
            cpu_restart = restart_due;
            restart_due = 1'b0;
            if (stall_left > 0) begin
                cpu_en = 1'b0;
                stall_left--;
                stall_used++;
            end else begin
                cpu_en = 1'b1;
                if (stall_used < STALL_MAX && pick(16) == 0)
                    stall_left = 1 + int'(pick(8));
            end
            // requests settle after the drive, well before the next rising edge
            #1;
            if (rom_en) begin
                if (rom_wait != 0) begin
                    errors++;
                    $display("ROM request issued while another one is outstanding");
                end
                if (exp_rom.size() == 0) begin
                    errors++;
                    $display("extra ROM request at address 0x%04h", rom_addr);
                end else begin
                    exp_v = exp_rom.pop_front();
                    if (rom_addr != code_addr_t'(exp_v)) begin
                        errors++;
                        $display("MISMATCH rom_addr expected 0x%04h got 0x%04h",
                                 exp_v[15:0], rom_addr);
                    end
                    done = (exp_rom.size() == 0);
                end
                rom_pend = rom_addr;
                rom_wait = 1 + int'(pick(4));
            end
            if (ram_rd_en) begin
                if (exp_rd.size() == 0) begin
                    errors++;
                    $display("extra RAM read at address 0x%02h", ram_rd_addr);
                end else begin
                    exp_v = exp_rd.pop_front();
                    if (ram_rd_addr != ram_addr_t'(exp_v)) begin
                        errors++;
                        $display("MISMATCH ram_rd_addr expected 0x%02h got 0x%02h",
                                 exp_v[7:0], ram_rd_addr);
                    end
                end
                rd_pend = ram_rd_addr;
                rd_wait = 1 + int'(pick(4));
            end
            if (ram_wr_en) begin
                writes++;
                if (exp_wr.size() == 0) begin
                    errors++;
                    $display("extra RAM write to address 0x%02h", ram_wr_addr);
                end else begin
                    exp_v = exp_wr.pop_front();
                    if (ram_wr_addr != ram_addr_t'(exp_v >> 8)) begin
                        errors++;
                        $display("MISMATCH ram_wr_addr expected 0x%02h got 0x%02h",
                                 exp_v[15:8], ram_wr_addr);
                    end
                    if (ram_wr_byte != data_t'(exp_v)) begin
                        errors++;
                        $display("MISMATCH ram_wr_byte expected 0x%02h got 0x%02h",
                                 exp_v[7:0], ram_wr_byte);
                    end
                end
                ram_mem[ram_wr_addr % 8] = ram_wr_byte;
                // the core sits in fetch one cycle after the store
                restart_due = (writes == restart_at);
            end
            if (!done && cycles >= limit) begin
                errors++;
                $display("timeout, program did not reach its end in %0d cycles", cycles);
                done = 1'b1;
            end
        end
    endtask

    initial begin
        rng = 32'd26983;
        errors = 0;
        rst = 1'b1;
        cpu_en = 1'b1;
        cpu_restart = 1'b0;
        rom_byte = 8'h00;
        rom_vld = 1'b0;
        ram_rd_byte = 8'h00;
        ram_rd_vld = 1'b0;
        build_program();
        restart_at = 3 + int'(pick(6));
        run_model();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        run_bus(n_instr * 12 + STALL_MAX + 40);
        if (exp_rom.size() != 0 || exp_rd.size() != 0 || exp_wr.size() != 0) begin
            errors++;
            $display("missing transactions, %0d ROM, %0d RAM reads, %0d RAM writes",
                     exp_rom.size(), exp_rd.size(), exp_wr.size());
        end
        $display("%0d errors over %0d model instructions", errors, n_instr);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
